// File: logic/zkbd_config.svh
`ifndef ZKBD_CONFIG_SVH
`define ZKBD_CONFIG_SVH

// flip-flops on each spi pin
`define ZKBD_SYNC_STAGES 2

// widths
`define ZKBD_BYTE_W 8
`define ZKBD_ROWS 8
`define ZKBD_ROW_W 5
`define ZKBD_JOY_W 5

// z80 ports
// keyboard and joystick compare the low byte only
`define ZKBD_PORT_FE 8'hFE
`define ZKBD_PORT_KJ 8'h1F
`define ZKBD_PORT_MX 16'hFBDF
`define ZKBD_PORT_MY 16'hFFDF
`define ZKBD_PORT_MB 16'hFADF

// register codes on the microcontroller link
`define ZKBD_LNK_KBD 8'h10
`define ZKBD_LNK_MX 8'h20
`define ZKBD_LNK_MY 8'h21
`define ZKBD_LNK_MB 8'h22
`define ZKBD_LNK_KJ 8'h23

`endif

// File: logic/spi_link_pkg.sv
`include "zkbd_config.svh"

package spi_link_pkg;

	// one byte as shifted in from the microcontroller
	typedef logic [`ZKBD_BYTE_W-1:0] lnk_byte_t;

	// target register, named by the first byte of a transaction
	typedef enum logic [`ZKBD_BYTE_W-1:0] {
		LNK_NONE = 8'h00,
		LNK_KBD  = `ZKBD_LNK_KBD,
		LNK_MX   = `ZKBD_LNK_MX,
		LNK_MY   = `ZKBD_LNK_MY,
		LNK_MB   = `ZKBD_LNK_MB,
		LNK_KJ   = `ZKBD_LNK_KJ
	} lnk_reg_e;

endpackage

// File: logic/zport_pkg.sv
`include "zkbd_config.svh"

package zport_pkg;

	// one keyboard half-row, active low
	typedef logic [`ZKBD_ROW_W-1:0] kbd_row_t;

	// whole matrix, index is the row number
	typedef kbd_row_t [`ZKBD_ROWS-1:0] kbd_matrix_t;

	// port hit by the current z80 address
	typedef enum logic [2:0] {
		ZP_NONE,
		ZP_KBD,
		ZP_MX,
		ZP_MY,
		ZP_MB,
		ZP_KJ
	} zport_sel_e;

endpackage

// File: logic/spi_slave_rx.sv
`timescale 1ns/1ps
`include "zkbd_config.svh"

module spi_slave_rx import spi_link_pkg::*; (
	input  logic      fclk,
	input  logic      rst_n,
	input  logic      spics_n,
	input  logic      spick,
	input  logic      spido,
	output lnk_reg_e  lnk_reg,
	output lnk_byte_t lnk_data,
	output logic      lnk_stb
);

	localparam int S = `ZKBD_SYNC_STAGES;

	// cs and ck carry one extra stage for edge detect
	logic [S:0]   cs_sr;
	logic [S:0]   ck_sr;
	logic [S-1:0] do_sr;

	logic       cs_s;
	logic       cs_fall;
	logic       cs_rise;
	logic       ck_rise;
	logic       do_s;
	logic [2:0] bit_cnt;
	logic [6:0] shift_q;
	logic       first_byte;
	lnk_byte_t  rx_byte;

	function automatic lnk_reg_e decode_reg(input lnk_byte_t code);
		case (code)
			`ZKBD_LNK_KBD: decode_reg = LNK_KBD;
			`ZKBD_LNK_MX:  decode_reg = LNK_MX;
			`ZKBD_LNK_MY:  decode_reg = LNK_MY;
			`ZKBD_LNK_MB:  decode_reg = LNK_MB;
			`ZKBD_LNK_KJ:  decode_reg = LNK_KJ;
			default:       decode_reg = LNK_NONE;
		endcase
	endfunction

	////////////////////
	// pin synchronizers
	////////////////////

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			cs_sr <= '1;
			ck_sr <= '0;
			do_sr <= '0;
		end else begin
			cs_sr <= {cs_sr[S-1:0], spics_n};
			ck_sr <= {ck_sr[S-1:0], spick};
			do_sr <= {do_sr[S-2:0], spido};
		end
	end

	assign cs_s    = cs_sr[S-1];
	assign cs_fall = !cs_sr[S-1] && cs_sr[S];
	assign cs_rise = cs_sr[S-1] && !cs_sr[S];
	assign ck_rise = ck_sr[S-1] && !ck_sr[S];
	assign do_s    = do_sr[S-1];

	// msb first, newest bit at the bottom
	assign rx_byte = {shift_q, do_s};

	////////////////////
	// byte assembly
	////////////////////

	always_ff @(posedge fclk) begin
		lnk_stb <= 1'b0;
		if (!rst_n) begin
			bit_cnt    <= '0;
			first_byte <= 1'b1;
			lnk_reg    <= LNK_NONE;
		end else if (cs_fall || cs_rise) begin
			// any partial byte is lost here
			bit_cnt    <= '0;
			first_byte <= 1'b1;
			if (cs_fall)
				lnk_reg <= LNK_NONE;
		end else if (ck_rise && !cs_s) begin
			shift_q <= rx_byte[6:0];
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				if (first_byte) begin
					first_byte <= 1'b0;
					lnk_reg    <= decode_reg(rx_byte);
				end else begin
					lnk_data <= rx_byte;
					lnk_stb  <= 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/input_regs.sv
`timescale 1ns/1ps
`include "zkbd_config.svh"

module input_regs import spi_link_pkg::*, zport_pkg::*; (
	input  logic                    fclk,
	input  logic                    rst_n,
	input  lnk_reg_e                lnk_reg,
	input  lnk_byte_t               lnk_data,
	input  logic                    lnk_stb,
	output kbd_matrix_t             kbd_rows,
	output logic [`ZKBD_BYTE_W-1:0] mouse_x,
	output logic [`ZKBD_BYTE_W-1:0] mouse_y,
	output logic [`ZKBD_BYTE_W-1:0] mouse_btn,
	output logic [`ZKBD_JOY_W-1:0]  joy
);

	localparam int ROW_SEL_W = $clog2(`ZKBD_ROWS);

	logic [ROW_SEL_W-1:0] row_sel;
	kbd_row_t             row_val;

	// keyboard byte has the row number on top, key bits below
	assign row_sel = lnk_data[`ZKBD_BYTE_W-1 -: ROW_SEL_W];
	assign row_val = lnk_data[`ZKBD_ROW_W-1:0];

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			// all keys released, mouse idle
			kbd_rows  <= '1;
			mouse_x   <= '1;
			mouse_y   <= '1;
			mouse_btn <= '1;
			joy       <= '0;
		end else if (lnk_stb) begin
			case (lnk_reg)
				LNK_KBD: kbd_rows[row_sel] <= row_val;
				LNK_MX:  mouse_x <= lnk_data;
				LNK_MY:  mouse_y <= lnk_data;
				LNK_MB:  mouse_btn <= lnk_data;
				LNK_KJ:  joy <= lnk_data[`ZKBD_JOY_W-1:0];
				// byte dropped for an unknown code
				default: ;
			endcase
		end
	end

endmodule

// File: logic/zport_read.sv
`timescale 1ns/1ps
`include "zkbd_config.svh"

module zport_read import zport_pkg::*; (
	input  logic                    fclk,
	input  logic                    rst_n,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  logic [15:0]             a,
	input  kbd_matrix_t             kbd_rows,
	input  logic [`ZKBD_BYTE_W-1:0] mouse_x,
	input  logic [`ZKBD_BYTE_W-1:0] mouse_y,
	input  logic [`ZKBD_BYTE_W-1:0] mouse_btn,
	input  logic [`ZKBD_JOY_W-1:0]  joy,
	output logic [`ZKBD_BYTE_W-1:0] d_out,
	output logic                    d_oe
);

	zport_sel_e              sel;
	kbd_row_t                keys;
	logic [`ZKBD_BYTE_W-1:0] rd_data;
	logic                    rd_hit;

	////////////////////
	// address decode
	////////////////////

	always_comb begin
		sel = ZP_NONE;
		if (a[7:0] == `ZKBD_PORT_FE)
			sel = ZP_KBD;
		else if (a[7:0] == `ZKBD_PORT_KJ)
			sel = ZP_KJ;
		else if (a == `ZKBD_PORT_MX)
			sel = ZP_MX;
		else if (a == `ZKBD_PORT_MY)
			sel = ZP_MY;
		else if (a == `ZKBD_PORT_MB)
			sel = ZP_MB;
	end

	// rows with a low address line are merged
	always_comb begin
		keys = '1;
		for (int r = 0; r < `ZKBD_ROWS; r++) begin
			if (!a[8+r])
				keys = keys & kbd_rows[r];
		end
	end

	always_comb begin
		case (sel)
			ZP_KBD:  rd_data = {{(`ZKBD_BYTE_W-`ZKBD_ROW_W){1'b1}}, keys};
			ZP_MX:   rd_data = mouse_x;
			ZP_MY:   rd_data = mouse_y;
			ZP_MB:   rd_data = mouse_btn;
			ZP_KJ:   rd_data = {{(`ZKBD_BYTE_W-`ZKBD_JOY_W){1'b0}}, joy};
			default: rd_data = '1;
		endcase
	end

	assign rd_hit = !iorq_n && !rd_n && (sel != ZP_NONE);

	////////////////////
	// bus outputs
	////////////////////

	always_ff @(posedge fclk) begin
		if (!rst_n)
			d_oe <= 1'b0;
		else
			d_oe <= rd_hit;
	end

	always_ff @(posedge fclk) begin
		if (rd_hit)
			d_out <= rd_data;
	end

endmodule

// File: logic/zkbdmus_top.sv
`timescale 1ns/1ps
`include "zkbd_config.svh"

module zkbdmus_top import spi_link_pkg::*, zport_pkg::*; (
	input  logic                    fclk,
	input  logic                    rst_n,
	input  logic                    spics_n,
	input  logic                    spick,
	input  logic                    spido,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  logic [15:0]             a,
	output logic [`ZKBD_BYTE_W-1:0] d_out,
	output logic                    d_oe
);

	lnk_reg_e                lnk_reg;
	lnk_byte_t               lnk_data;
	logic                    lnk_stb;
	kbd_matrix_t             kbd_rows;
	logic [`ZKBD_BYTE_W-1:0] mouse_x;
	logic [`ZKBD_BYTE_W-1:0] mouse_y;
	logic [`ZKBD_BYTE_W-1:0] mouse_btn;
	logic [`ZKBD_JOY_W-1:0]  joy;

	// link from the microcontroller
	spi_slave_rx i_spi_slave_rx (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.spics_n  (spics_n),
		.spick    (spick),
		.spido    (spido),
		.lnk_reg  (lnk_reg),
		.lnk_data (lnk_data),
		.lnk_stb  (lnk_stb)
	);

	input_regs i_input_regs (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.lnk_reg   (lnk_reg),
		.lnk_data  (lnk_data),
		.lnk_stb   (lnk_stb),
		.kbd_rows  (kbd_rows),
		.mouse_x   (mouse_x),
		.mouse_y   (mouse_y),
		.mouse_btn (mouse_btn),
		.joy       (joy)
	);

	// z80 side
	zport_read i_zport_read (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.a         (a),
		.kbd_rows  (kbd_rows),
		.mouse_x   (mouse_x),
		.mouse_y   (mouse_y),
		.mouse_btn (mouse_btn),
		.joy       (joy),
		.d_out     (d_out),
		.d_oe      (d_oe)
	);

endmodule

// File: testbench/zkbdmus_props.sv
`timescale 1ns/1ps
`include "zkbd_config.svh"

module zkbdmus_props (
	input logic        fclk,
	input logic        rst_n,
	input logic        iorq_n,
	input logic        rd_n,
	input logic [15:0] a,
	input logic        d_oe
);

	int unsigned fail_cnt = 0;

	logic port_hit;
	logic read_hit;

	// keyboard and joystick decode on the low byte only
	assign port_hit = (a[7:0] == `ZKBD_PORT_FE) || (a[7:0] == `ZKBD_PORT_KJ) ||
		(a == `ZKBD_PORT_MX) || (a == `ZKBD_PORT_MY) || (a == `ZKBD_PORT_MB);
	assign read_hit = !iorq_n && !rd_n && port_hit;

	oe_low_in_reset: assert property (@(posedge fclk) !rst_n |=> !d_oe)
		else begin
			$error("d_oe high after a reset cycle");
			fail_cnt++;
		end

	oe_needs_read: assert property (@(posedge fclk) disable iff (!rst_n)
		d_oe |-> $past(read_hit))
		else begin
			$error("d_oe high without a read of a mapped port");
			fail_cnt++;
		end

	read_gives_oe: assert property (@(posedge fclk) disable iff (!rst_n)
		read_hit |=> d_oe)
		else begin
			$error("read of a mapped port without d_oe");
			fail_cnt++;
		end

endmodule

bind zkbdmus_top zkbdmus_props i_zkbdmus_props (
	.fclk   (fclk),
	.rst_n  (rst_n),
	.iorq_n (iorq_n),
	.rd_n   (rd_n),
	.a      (a),
	.d_oe   (d_oe)
);

// File: testbench/zkbdmus_tb.sv
`timescale 1ns/1ps
`include "zkbd_config.svh"

module zkbdmus_tb;

	logic        fclk;
	logic        rst_n;
	logic        spics_n;
	logic        spick;
	logic        spido;
	logic        iorq_n;
	logic        rd_n;
	logic [15:0] a;
	logic [7:0]  d_out;
	logic        d_oe;

	// reference state of the buffer
	logic [4:0] m_rows [8];
	logic [7:0] m_mx;
	logic [7:0] m_my;
	logic [7:0] m_mb;
	logic [4:0] m_joy;

	logic [7:0]  v1;
	logic [7:0]  v2;

	zkbdmus_top i_zkbdmus_top (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.spics_n (spics_n),
		.spick   (spick),
		.spido   (spido),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.a       (a),
		.d_out   (d_out),
		.d_oe    (d_oe)
	);

	initial begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge fclk);
		#2;
	endtask

	task automatic hold_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	// stop at the first concurrent assertion failure
	always @(posedge fclk) begin
		if (i_zkbdmus_top.i_zkbdmus_props.fail_cnt != 0)
			abort_run("a concurrent assertion on d_oe failed");
	end

	////////////////////
	// spi side
	////////////////////

	task automatic spi_begin();
		spics_n = 1'b0;
		hold_cycles(4);
	endtask

	task automatic spi_end();
		spics_n = 1'b1;
		hold_cycles(4);
	endtask

	// msb first, nbits < 8 leaves a partial byte
	task automatic spi_send(input logic [7:0] b, input int nbits);
		for (int i = 7; i > 7 - nbits; i--) begin
			spido = b[i];
			spick = 1'b0;
			hold_cycles(4);
			spick = 1'b1;
			hold_cycles(4);
		end
		spick = 1'b0;
		hold_cycles(4);
	endtask

	task automatic write_reg(input logic [7:0] code, input logic [7:0] data);
		spi_begin();
		spi_send(code, 8);
		spi_send(data, 8);
		spi_end();
	endtask

	////////////////////
	// z80 side
	////////////////////

	function automatic logic [7:0] kbd_expect(input logic [15:0] addr);
		logic [4:0] res;
		res = 5'h1f;
		for (int r = 0; r < 8; r++) begin
			if (!addr[8+r])
				res = res & m_rows[r];
		end
		return {3'b111, res};
	endfunction

	task automatic check_port(input logic [15:0] addr, input logic [7:0] exp);
		int         waited;
		logic [7:0] got;
		waited = 0;
		a = addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		next_cycle();
		while (!d_oe && waited < 20) begin
			next_cycle();
			waited++;
		end
		if (!d_oe)
			abort_run($sformatf("timeout waiting for d_oe on a read of port %h", addr));
		got = d_out;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		next_cycle();
		assert (got === exp)
			else abort_run($sformatf("Error: d_out port %h expected %h actual %h",
				addr, exp, got));
		assert (d_oe === 1'b0)
			else abort_run($sformatf("Error: d_oe after read expected 0 actual %h", d_oe));
	endtask

	task automatic check_unmapped(input logic [15:0] addr);
		a = addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		for (int i = 0; i < 6; i++) begin
			next_cycle();
			assert (d_oe === 1'b0)
				else abort_run($sformatf("Error: d_oe port %h expected 0 actual %h",
					addr, d_oe));
		end
		iorq_n = 1'b1;
		rd_n = 1'b1;
		next_cycle();
	endtask

	task automatic check_all();
		check_port(16'hfbdf, m_mx);
		check_port(16'hffdf, m_my);
		check_port(16'hfadf, m_mb);
		check_port(16'h001f, {3'b000, m_joy});
		check_port(16'h00fe, kbd_expect(16'h00fe));
	endtask

	initial begin
		void'($urandom(32'hcdedf234));
		rst_n = 1'b0;
		spics_n = 1'b1;
		spick = 1'b0;
		spido = 1'b0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		a = 16'h0000;
		for (int r = 0; r < 8; r++)
			m_rows[r] = 5'h1f;
		m_mx = 8'hff;
		m_my = 8'hff;
		m_mb = 8'hff;
		m_joy = 5'h00;
		repeat (2) @(posedge fclk);
		#2;
		rst_n = 1'b1;
		hold_cycles(2);

		// reset values
		check_port({8'($urandom), 8'hfe}, 8'hff);
		check_port(16'h001f, 8'h00);
		check_port(16'hfbdf, 8'hff);

		// keyboard rows 2 and 5
		m_rows[2] = 5'($urandom);
		write_reg(`ZKBD_LNK_KBD, {3'd2, m_rows[2]});
		m_rows[5] = 5'($urandom);
		write_reg(`ZKBD_LNK_KBD, {3'd5, m_rows[5]});
		check_port(16'hfbfe, kbd_expect(16'hfbfe));
		check_port(16'hdbfe, kbd_expect(16'hdbfe));

		// mouse registers
		m_mx = 8'($urandom);
		write_reg(`ZKBD_LNK_MX, m_mx);
		m_my = 8'($urandom);
		write_reg(`ZKBD_LNK_MY, m_my);
		m_mb = 8'($urandom);
		write_reg(`ZKBD_LNK_MB, m_mb);
		check_port(16'hfbdf, m_mx);
		check_port(16'hffdf, m_my);
		check_port(16'hfadf, m_mb);

		// second of two data bytes stays
		v1 = 8'($urandom);
		v2 = 8'($urandom);
		spi_begin();
		spi_send(`ZKBD_LNK_MY, 8);
		spi_send(v1, 8);
		spi_send(v2, 8);
		spi_end();
		m_my = v2;
		check_port(16'hffdf, m_my);

		// joystick is 5 bits wide
		v1 = 8'($urandom);
		write_reg(`ZKBD_LNK_KJ, v1);
		m_joy = v1[4:0];
		check_port(16'h001f, {3'b000, m_joy});

		// cs rises mid byte
		spi_begin();
		spi_send(`ZKBD_LNK_MX, 8);
		spi_send(~m_mx, 5);
		spi_end();
		check_port(16'hfbdf, m_mx);

		// unknown register code
		write_reg(8'h55, 8'($urandom));
		check_all();

		check_unmapped(16'h7ffd);
		hold_cycles(2);

		if (i_zkbdmus_top.i_zkbdmus_props.fail_cnt == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			abort_run("concurrent assertions on d_oe reported failures");
		end
	end

endmodule

// File: src.f
+incdir+logic
logic/spi_link_pkg.sv
logic/zport_pkg.sv
logic/spi_slave_rx.sv
logic/input_regs.sv
logic/zport_read.sv
logic/zkbdmus_top.sv
testbench/zkbdmus_props.sv
testbench/zkbdmus_tb.sv
